/* gpuMemCtrl.f */
+incdir+.
hostProtoPkg.sv
sramScenePkg.sv
uartWordRx.sv
uartWordTx.sv
cmdSequencer.sv
sramPort.sv
sceneLoader.sv
cameraRegs.sv
gpuMemCtrl.sv
tbClockGen.sv
tb_gpuMemCtrl.sv

/* tb_gpuMemCtrl.sv */
`timescale 1ns/10ps
`include "gpuMemCtrl_macros.svh"
`default_nettype none

module tb_gpuMemCtrl;

  localparam logic [15:0] TAG_REQUEST = 16'hAAAA;
  localparam logic [15:0] TAG_GPU     = 16'hCCCC;
  localparam logic [15:0] TAG_CAM     = 16'hBBBB;
  localparam logic [15:0] TAG_OBJ     = 16'hEEEE;
  localparam logic [15:0] TAG_CLS_OBJ = 16'h8888;
  localparam logic [15:0] TAG_TMATRIX = 16'hABCD;
  localparam logic [15:0] TAG_REFRESH = 16'h1234;
  localparam logic [15:0] TAG_FINAL   = 16'hFFFF;
  localparam logic [15:0] TAG_ERROR   = 16'h1414;
  localparam logic [15:0] TAG_BUSY    = 16'h4141;

  localparam logic [31:0] NOT_WRITTEN   = 32'hFFFF_0000; // outside any 16-bit word
  localparam int          REPLY_TIMEOUT = 1000;
  // five writes, error case and retry, refresh with probe, bad refresh, rx error case
  localparam int PLAN_WORDS = (2 + 5 + 14 + 1 + 12 + 5 * 3) + (5 + 3 + 2 + 3) + 2 + 1 + (2 + 1 + 3);

  logic                    clock;
  logic                    reset;
  logic [7:0]              iRxByte;
  logic                    iRxReady;
  logic                    iRxError;
  logic                    iTxSent;
  logic [7:0]              oTxByte;
  logic                    oTxReady;
  wire  [`WORD_WIDTH-1:0]  ioData;
  logic                    iValidRead;
  logic [`ADDR_WIDTH-1:0]  oAddress;
  logic                    oValidRequest;
  logic                    oWrite;
  logic                    oEnable;
  logic [`WORD_WIDTH-1:0]  oCamVerX;
  logic [`WORD_WIDTH-1:0]  oCamVerY;
  logic [`WORD_WIDTH-1:0]  oCamVerZ;
  logic [`WORD_WIDTH-1:0]  oCamDc;
  logic                    oCamUpdate;

  logic [15:0] sramMem  [logic [21:0]];
  logic [15:0] writeLog [logic [21:0]]; // writes of the current command
  logic [15:0] sramRdData;
  logic        sramDrive;
  logic [15:0] replyQ [$];
  logic [7:0]  highByte;
  logic        haveHigh;
  int          camUpdates;
  logic [15:0] camExp [0:3];

  assign ioData = sramDrive ? sramRdData : 16'hzzzz;

  tbClockGen clockGen (
    .clock (clock),
    .reset (reset)
  );

  gpuMemCtrl dut (
    .iClock        (clock),
    .reset         (reset),
    .iRxByte       (iRxByte),
    .iRxReady      (iRxReady),
    .iRxError      (iRxError),
    .iTxSent       (iTxSent),
    .oTxByte       (oTxByte),
    .oTxReady      (oTxReady),
    .ioData        (ioData),
    .iValidRead    (iValidRead),
    .oAddress      (oAddress),
    .oValidRequest (oValidRequest),
    .oWrite        (oWrite),
    .oEnable       (oEnable),
    .oCamVerX      (oCamVerX),
    .oCamVerY      (oCamVerY),
    .oCamVerZ      (oCamVerZ),
    .oCamDc        (oCamDc),
    .oCamUpdate    (oCamUpdate)
  );

  ////////////////////////////////////////
  // reference rules and checks
  function automatic int blockSizeOf(input logic [15:0] tag);
    case (tag)
      TAG_REQUEST: return 2;
      TAG_CAM:     return 5;
      TAG_OBJ:     return 14;
      TAG_CLS_OBJ: return 1;
      default:     return 12; // TMATRIX
    endcase
  endfunction

  function automatic logic [15:0] readSram(input logic [21:0] addr);
    if (sramMem.exists(addr)) begin
      return sramMem[addr];
    end
    return addr[15:0] ^ {addr[21:16], 10'h2A5}; // fill covers every address bit
  endfunction

  function automatic logic [31:0] loggedWrite(input logic [21:0] addr);
    if (writeLog.exists(addr)) begin
      return {16'h0000, writeLog[addr]};
    end
    return NOT_WRITTEN;
  endfunction

  task automatic abortRun();
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compareValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
    if (got !== expected) begin
      $display("[FAIL] %0d ns: %s: got %h, expected %h", $time, what, got, expected);
      abortRun();
    end
  endtask

  ////////////////////////////////////////
  // host side
  task automatic sendByte(input logic [7:0] value, input int minGap, input int maxGap);
    repeat ($urandom_range(maxGap, minGap)) @(negedge clock);
    iRxByte  = value;
    iRxReady = 1'b1;
    @(negedge clock);
    iRxReady = 1'b0;
  endtask

  task automatic sendWord(input logic [15:0] value, input int minGap, input int maxGap);
    sendByte(value[15:8], minGap, maxGap); // high byte first
    sendByte(value[7:0], minGap, maxGap);
  endtask

  task automatic waitReplies(input int count);
    int cycles;
    cycles = 0;
    while (replyQ.size() < count) begin
      @(negedge clock);
      cycles++;
      if (cycles > REPLY_TIMEOUT) begin
        $display("timeout: waited for %0d reply words, only %0d arrived", count, replyQ.size());
        abortRun();
      end
    end
  endtask

  task automatic expectReply(input logic [15:0] expected, input string what);
    logic [15:0] got;
    got = replyQ.pop_front();
    compareValue(what, {16'h0000, got}, {16'h0000, expected});
  endtask

  task automatic waitSramIdle();
    int cycles;
    cycles = 0;
    while (oValidRequest) begin
      @(negedge clock);
      cycles++;
      if (cycles > REPLY_TIMEOUT) begin
        $display("timeout: SRAM request never completed");
        abortRun();
      end
    end
  endtask

  task automatic checkCamera(input string what);
    compareValue({what, " VerX"}, oCamVerX, camExp[0]);
    compareValue({what, " VerY"}, oCamVerY, camExp[1]);
    compareValue({what, " VerZ"}, oCamVerZ, camExp[2]);
    compareValue({what, " Dc"}, oCamDc, camExp[3]);
  endtask

  // one block write, closed by FINAL or by a wrong word
  task automatic runWriteCommand(input logic [15:0] tag, input bit closeOk);
    int          size;
    int          i;
    bit          storesFinal;
    logic [21:0] base;
    logic [15:0] data [$];
    logic [15:0] lastWord;
    size        = blockSizeOf(tag);
    storesFinal = (tag != TAG_CLS_OBJ) && (tag != TAG_TMATRIX);
    base        = 22'($urandom_range(16'hFE00, 16'h0100));
    compareValue("stray reply before command", replyQ.size(), 0);
    writeLog.delete();
    sendWord(tag, 8, 16);
    sendWord(base[15:0], 8, 16);
    for (i = 0; i < size; i++) begin
      data.push_back(16'($urandom));
      sendWord(data[i], 8, 16);
    end
    lastWord = closeOk ? TAG_FINAL : 16'($urandom_range(16'hFFFE, 0));
    sendWord(lastWord, 8, 16);
    waitReplies(2);
    expectReply(~tag, "echo reply");
    expectReply(closeOk ? tag : TAG_ERROR, "closing reply");
    waitSramIdle();
    compareValue("write count", writeLog.num(), size + (closeOk && storesFinal));
    for (i = 0; i < size; i++) begin
      compareValue("block data word", loggedWrite(base + 22'(i)), {16'h0000, data[i]});
    end
    compareValue("stop address", loggedWrite(base + 22'(size)),
                 (closeOk && storesFinal) ? {16'h0000, TAG_FINAL} : NOT_WRITTEN);
  endtask

  ////////////////////////////////////////
  // UART transmit side, strobes iTxSent per byte
  initial begin
    iTxSent  = 1'b0;
    haveHigh = 1'b0;
    forever begin
      @(negedge clock);
      iTxSent = 1'b0;
      if (oTxReady) begin
        if (haveHigh) begin
          replyQ.push_back({highByte, oTxByte});
        end else begin
          highByte = oTxByte;
        end
        haveHigh = !haveHigh;
        repeat ($urandom_range(4, 1)) @(negedge clock);
        iTxSent = 1'b1;
      end
    end
  end

  // SRAM model, acknowledges 1 to 4 cycles after the request
  initial begin
    iValidRead = 1'b0;
    sramDrive  = 1'b0;
    forever begin
      @(negedge clock);
      if (oValidRequest) begin
        repeat ($urandom_range(3, 0)) @(negedge clock);
        if (oWrite) begin
          sramMem[oAddress]  = ioData;
          writeLog[oAddress] = ioData;
        end else begin
          compareValue("oEnable during scene read", oEnable, 1);
          sramRdData = readSram(oAddress);
          sramDrive  = 1'b1;
        end
        iValidRead = 1'b1;
        @(negedge clock);
        iValidRead = 1'b0;
        sramDrive  = 1'b0;
      end
    end
  end

  always @(posedge clock) begin
    if (oCamUpdate) begin
      camUpdates <= camUpdates + 1;
    end
  end

  initial begin
    repeat (PLAN_WORDS * 200) @(posedge clock);
    $display("watchdog: run did not finish within %0d cycles", PLAN_WORDS * 200);
    abortRun();
  end

  ////////////////////////////////////////
  initial begin
    int i;
    void'($urandom(32'h190f_7e76));
    iRxByte    = 8'h00;
    iRxReady   = 1'b0;
    iRxError   = 1'b0;
    camUpdates = 0;
    @(posedge clock);
    while (reset) @(posedge clock);
    @(negedge clock);
    compareValue("oTxReady after reset", oTxReady, 0);
    compareValue("oValidRequest after reset", oValidRequest, 0);
    compareValue("oWrite after reset", oWrite, 0);
    compareValue("oEnable after reset", oEnable, 0);
    compareValue("oCamUpdate after reset", oCamUpdate, 0);

    // all write commands, CLS_OBJ and TMATRIX skip the final tag
    runWriteCommand(TAG_REQUEST, 1'b1);
    runWriteCommand(TAG_CAM, 1'b1);
    runWriteCommand(TAG_OBJ, 1'b1);
    runWriteCommand(TAG_CLS_OBJ, 1'b1);
    runWriteCommand(TAG_TMATRIX, 1'b1);

    // wrong closing word, then recovery
    runWriteCommand(TAG_CAM, 1'b0);
    runWriteCommand(TAG_REQUEST, 1'b1);

    // refresh over a good scene, with a word sent while it runs
    sramMem[22'd0] = TAG_GPU;
    sramMem[22'd1] = 16'($urandom); // object count
    sramMem[22'd2] = TAG_CAM;
    for (i = 0; i < 4; i++) begin
      camExp[i]             = 16'($urandom);
      sramMem[22'(3 + i)] = camExp[i];
    end
    camUpdates = 0;
    sendWord(TAG_REFRESH, 8, 16);
    sendWord(16'h0F0F, 1, 2);
    waitReplies(2);
    expectReply(TAG_BUSY, "reply during refresh");
    expectReply(~TAG_REFRESH, "refresh reply");
    checkCamera("camera after refresh");
    compareValue("camera update strobes", camUpdates, 1);
    compareValue("oEnable after refresh", oEnable, 0);

    // corrupt GPU tag leaves the camera alone
    sramMem[22'd0] = 16'hC0C0;
    camUpdates     = 0;
    sendWord(TAG_REFRESH, 8, 16);
    waitReplies(1);
    expectReply(TAG_ERROR, "bad scene reply");
    checkCamera("camera after bad refresh");
    compareValue("camera update strobes", camUpdates, 0);

    // receive error drops the held byte, 5AA5 is no command
    sendByte(8'hAA, 8, 16);
    iRxError = 1'b1;
    @(negedge clock);
    iRxError = 1'b0;
    sendByte(8'h5A, 8, 16);
    sendByte(8'hA5, 8, 16);
    repeat (60) @(negedge clock);
    compareValue("reply to unknown tag", replyQ.size(), 0);
    runWriteCommand(TAG_CLS_OBJ, 1'b1);

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tbClockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module tbClockGen #(
  parameter int HALF_PERIOD = 5 // 10 ns clock
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(HALF_PERIOD) clock = ~clock;
  end

  // two rising edges under reset, release on a falling edge
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

/* gpuMemCtrl.sv */
`timescale 1ns/10ps
`include "gpuMemCtrl_macros.svh"
`default_nettype none

module gpuMemCtrl (
  input  logic                    iClock,
  input  logic                    reset,
  input  logic [7:0]              iRxByte,
  input  logic                    iRxReady,
  input  logic                    iRxError,
  input  logic                    iTxSent,
  output logic [7:0]              oTxByte,
  output logic                    oTxReady,
  inout  wire  [`WORD_WIDTH-1:0]  ioData,
  input  logic                    iValidRead,
  output sramScenePkg::sramAddr_t oAddress,
  output logic                    oValidRequest,
  output logic                    oWrite,
  output logic                    oEnable,
  output sramScenePkg::sramData_t oCamVerX,
  output sramScenePkg::sramData_t oCamVerY,
  output sramScenePkg::sramData_t oCamVerZ,
  output sramScenePkg::sramData_t oCamDc,
  output logic                    oCamUpdate
);

  import hostProtoPkg::*;
  import sramScenePkg::*;

  ////////////////////////////////////////
  // host link
  hostWord_t rxWord;
  logic      rxWordValid;
  hostWord_t txWord;
  logic      txWordValid;
  logic      txWordReady;

  // SRAM requesters
  logic      wrReq;
  sramAddr_t wrAddr;
  sramData_t wrData;
  logic      wrAccept;
  logic      rdReq;
  sramAddr_t rdAddr;
  sramData_t rdData;
  logic      rdValid;

  // refresh and camera load
  logic      refreshStart;
  logic      refreshDone;
  logic      refreshError;
  logic      camWrite;
  camIndex_t camIndex;
  sramData_t camData;
  logic      camCommit;

  uartWordRx uRx (
    .iClock    (iClock),
    .reset     (reset),
    .rxByte    (iRxByte),
    .rxReady   (iRxReady),
    .rxError   (iRxError),
    .word      (rxWord),
    .wordValid (rxWordValid)
  );

  uartWordTx uTx (
    .iClock      (iClock),
    .reset       (reset),
    .txWord      (txWord),
    .txWordValid (txWordValid),
    .txWordReady (txWordReady),
    .txSent      (iTxSent),
    .txByte      (oTxByte),
    .txReady     (oTxReady)
  );

  cmdSequencer uSeq (
    .iClock       (iClock),
    .reset        (reset),
    .word         (rxWord),
    .wordValid    (rxWordValid),
    .txWord       (txWord),
    .txWordValid  (txWordValid),
    .txWordReady  (txWordReady),
    .wrReq        (wrReq),
    .wrAddr       (wrAddr),
    .wrData       (wrData),
    .wrAccept     (wrAccept),
    .refreshStart (refreshStart),
    .refreshDone  (refreshDone),
    .refreshError (refreshError)
  );

  sramPort uSram (
    .iClock       (iClock),
    .reset        (reset),
    .wrReq        (wrReq),
    .wrAddr       (wrAddr),
    .wrData       (wrData),
    .wrAccept     (wrAccept),
    .rdReq        (rdReq),
    .rdAddr       (rdAddr),
    .rdData       (rdData),
    .rdValid      (rdValid),
    .data         (ioData),
    .validRead    (iValidRead),
    .address      (oAddress),
    .validRequest (oValidRequest),
    .write        (oWrite)
  );

  sceneLoader uLoader (
    .iClock       (iClock),
    .reset        (reset),
    .refreshStart (refreshStart),
    .refreshDone  (refreshDone),
    .refreshError (refreshError),
    .rdReq        (rdReq),
    .rdAddr       (rdAddr),
    .rdData       (rdData),
    .rdValid      (rdValid),
    .enable       (oEnable),
    .camWrite     (camWrite),
    .camIndex     (camIndex),
    .camData      (camData),
    .camCommit    (camCommit)
  );

  cameraRegs uCam (
    .iClock    (iClock),
    .reset     (reset),
    .camWrite  (camWrite),
    .camIndex  (camIndex),
    .camData   (camData),
    .camCommit (camCommit),
    .camVerX   (oCamVerX),
    .camVerY   (oCamVerY),
    .camVerZ   (oCamVerZ),
    .camDc     (oCamDc),
    .camUpdate (oCamUpdate)
  );

endmodule

`default_nettype wire

/* cameraRegs.sv */
`timescale 1ns/10ps
`include "gpuMemCtrl_macros.svh"
`default_nettype none

module cameraRegs (
  input  logic                    iClock,
  input  logic                    reset,
  input  logic                    camWrite,
  input  sramScenePkg::camIndex_t camIndex,
  input  sramScenePkg::sramData_t camData,
  input  logic                    camCommit,
  output sramScenePkg::sramData_t camVerX,
  output sramScenePkg::sramData_t camVerY,
  output sramScenePkg::sramData_t camVerZ,
  output sramScenePkg::sramData_t camDc,
  output logic                    camUpdate
);

  import sramScenePkg::*;

  sramData_t shadow [0:`CAM_WORDS-1];

  always_ff @(posedge iClock) begin
    if (camWrite) begin
      shadow[camIndex] <= camData;
    end
    if (camCommit) begin // all four move together
      camVerX <= shadow[CAM_VER_X];
      camVerY <= shadow[CAM_VER_Y];
      camVerZ <= shadow[CAM_VER_Z];
      camDc   <= shadow[CAM_DC];
    end
  end

  always_ff @(posedge iClock) begin
    if (reset) begin
      camUpdate <= 1'b0;
    end else begin
      camUpdate <= camCommit;
    end
  end

endmodule

`default_nettype wire

/* sceneLoader.sv */
`timescale 1ns/10ps
`include "gpuMemCtrl_macros.svh"
`default_nettype none

module sceneLoader (
  input  logic                    iClock,
  input  logic                    reset,
  input  logic                    refreshStart,
  output logic                    refreshDone,
  output logic                    refreshError,
  output logic                    rdReq,
  output sramScenePkg::sramAddr_t rdAddr,
  input  sramScenePkg::sramData_t rdData,
  input  logic                    rdValid,
  output logic                    enable,
  output logic                    camWrite,
  output sramScenePkg::camIndex_t camIndex,
  output sramScenePkg::sramData_t camData,
  output logic                    camCommit
);

  import hostProtoPkg::*;
  import sramScenePkg::*;

  // scene header: GPU tag, object count, CAM tag, then camera words
  localparam int STEP_GPU     = 0;
  localparam int STEP_CAM_TAG = 2;
  localparam int STEP_CAM0    = 3;
  localparam int STEP_COMMIT  = STEP_CAM0 + `CAM_WORDS;

  logic [$clog2(STEP_COMMIT+1)-1:0] step;
  hostWord_t                        rdWord;
  logic                             tagBad;

  assign rdWord = hostWord_t'(rdData);
  assign rdAddr = sramAddr_t'(`SCENE_BASE_ADDR) + sramAddr_t'(step);
  assign tagBad = (step == STEP_GPU && rdWord.tag != TAG_GPU) ||
                  (step == STEP_CAM_TAG && rdWord.tag != TAG_CAM);

  always_ff @(posedge iClock) begin
    refreshDone <= 1'b0;
    camWrite    <= 1'b0;
    camCommit   <= 1'b0;
    if (reset) begin
      enable <= 1'b0;
      rdReq  <= 1'b0;
    end else if (!enable) begin
      if (refreshStart) begin
        enable <= 1'b1;
        rdReq  <= 1'b1;
        step   <= '0;
      end
    end else if (step == STEP_COMMIT) begin
      // last camera word is in the shadow set by now
      camCommit    <= 1'b1;
      refreshDone  <= 1'b1;
      refreshError <= 1'b0;
      enable       <= 1'b0;
    end else if (rdValid) begin
      if (tagBad) begin
        rdReq        <= 1'b0;
        enable       <= 1'b0;
        refreshDone  <= 1'b1;
        refreshError <= 1'b1; // no commit
      end else begin
        if (step >= STEP_CAM0) begin
          camWrite <= 1'b1;
          camIndex <= camIndex_t'(step - STEP_CAM0);
          camData  <= rdData;
        end
        rdReq <= (step != STEP_COMMIT - 1);
        step  <= step + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* sramPort.sv */
`timescale 1ns/10ps
`include "gpuMemCtrl_macros.svh"
`default_nettype none

module sramPort (
  input  logic                    iClock,
  input  logic                    reset,
  input  logic                    wrReq,
  input  sramScenePkg::sramAddr_t wrAddr,
  input  sramScenePkg::sramData_t wrData,
  output logic                    wrAccept,
  input  logic                    rdReq,
  input  sramScenePkg::sramAddr_t rdAddr,
  output sramScenePkg::sramData_t rdData,
  output logic                    rdValid,
  inout  wire  [`WORD_WIDTH-1:0]  data,
  input  logic                    validRead,
  output sramScenePkg::sramAddr_t address,
  output logic                    validRequest,
  output logic                    write
);

  import sramScenePkg::*;

  sramData_t wrBuf;
  logic      ackCycle; // requester still sees its old request

  assign ackCycle = wrAccept || rdValid;
  assign data     = write ? wrBuf : 'z;

  always_ff @(posedge iClock) begin
    wrAccept <= 1'b0;
    rdValid  <= 1'b0;
    if (reset) begin
      validRequest <= 1'b0;
      write        <= 1'b0;
    end else if (validRequest) begin
      if (validRead) begin
        validRequest <= 1'b0;
        write        <= 1'b0;
        wrAccept     <= write;
        rdValid      <= !write;
        if (!write) begin
          rdData <= data;
        end
      end
    end else if (!ackCycle && wrReq) begin // writer first
      validRequest <= 1'b1;
      write        <= 1'b1;
      address      <= wrAddr;
      wrBuf        <= wrData;
    end else if (!ackCycle && rdReq) begin
      validRequest <= 1'b1;
      address      <= rdAddr;
    end
  end

  // SRAM acknowledges only a request in flight
  assert property (@(posedge iClock) disable iff (reset)
    validRead |-> validRequest);

endmodule

`default_nettype wire

/* cmdSequencer.sv */
`timescale 1ns/10ps
`include "gpuMemCtrl_macros.svh"
`default_nettype none

module cmdSequencer (
  input  logic                    iClock,
  input  logic                    reset,
  input  hostProtoPkg::hostWord_t word,
  input  logic                    wordValid,
  output hostProtoPkg::hostWord_t txWord,
  output logic                    txWordValid,
  input  logic                    txWordReady,
  output logic                    wrReq,
  output sramScenePkg::sramAddr_t wrAddr,
  output sramScenePkg::sramData_t wrData,
  input  logic                    wrAccept,
  output logic                    refreshStart,
  input  logic                    refreshDone,
  input  logic                    refreshError
);

  import hostProtoPkg::*;
  import sramScenePkg::*;

  cmdState_t state;
  cmdTag_t   origTag;    // replied when the block closes
  sramAddr_t tagSize;
  logic      isWriteTag;
  logic      skipFinal;  // final tag not stored
  sramAddr_t blockSize;
  sramAddr_t curAddr;
  sramAddr_t stopAddr;

  ////////////////////////////////////////
  // block size per write command
  always_comb begin
    isWriteTag = 1'b1;
    case (word.tag)
      TAG_REQUEST: tagSize = sramAddr_t'(`INIT_BLOCK_SIZE);
      TAG_CAM:     tagSize = sramAddr_t'(`CAM_BLOCK_SIZE);
      TAG_OBJ:     tagSize = sramAddr_t'(`OBJ_BLOCK_SIZE);
      TAG_CLS_OBJ: tagSize = sramAddr_t'(`CLS_OBJ_BLOCK_SIZE);
      TAG_TMATRIX: tagSize = sramAddr_t'(`MATRIX_BLOCK_SIZE);
      default: begin
        tagSize    = '0;
        isWriteTag = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // command FSM
  always_ff @(posedge iClock) begin
    refreshStart <= 1'b0;
    if (txWordValid && txWordReady) begin
      txWordValid <= 1'b0;
    end
    if (wrAccept) begin
      wrReq <= 1'b0;
    end
    if (reset) begin
      state       <= ST_IDLE;
      txWordValid <= 1'b0;
      wrReq       <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (wordValid && isWriteTag) begin
            txWord      <= hostWord_t'(~word.tag); // echo
            txWordValid <= 1'b1;
            origTag     <= word.tag;
            blockSize   <= tagSize;
            skipFinal   <= (word.tag == TAG_CLS_OBJ) || (word.tag == TAG_TMATRIX);
            state       <= ST_ADDR;
          end else if (wordValid && word.tag == TAG_REFRESH) begin
            refreshStart <= 1'b1;
            state        <= ST_REFRESH;
          end
        end
        ST_ADDR: begin
          if (wordValid) begin
            curAddr  <= sramAddr_t'(word);
            stopAddr <= sramAddr_t'(word) + blockSize;
            state    <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (wordValid && curAddr != stopAddr) begin
            wrReq   <= 1'b1;
            wrAddr  <= curAddr;
            wrData  <= sramData_t'(word);
            curAddr <= curAddr + 1'b1;
          end else if (wordValid) begin
            if (word.tag == TAG_FINAL) begin
              if (!skipFinal) begin
                wrReq  <= 1'b1;
                wrAddr <= stopAddr;
                wrData <= sramData_t'(word);
              end
              txWord.tag <= origTag;
            end else begin
              txWord.tag <= TAG_ERROR; // block not closed properly
            end
            txWordValid <= 1'b1;
            state       <= ST_IDLE;
          end
        end
        ST_REFRESH: begin
          if (refreshDone) begin
            txWord      <= refreshError ? hostWord_t'(TAG_ERROR) : hostWord_t'(~TAG_REFRESH);
            txWordValid <= 1'b1;
            state       <= ST_IDLE;
          end else if (wordValid) begin
            txWord.tag  <= TAG_BUSY;
            txWordValid <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // a data word must not overrun the SRAM write before it
  assert property (@(posedge iClock) disable iff (reset)
    wrReq && !wrAccept |-> !wordValid);

endmodule

`default_nettype wire

/* uartWordTx.sv */
`timescale 1ns/10ps
`include "gpuMemCtrl_macros.svh"
`default_nettype none

module uartWordTx (
  input  logic                    iClock,
  input  logic                    reset,
  input  hostProtoPkg::hostWord_t txWord,
  input  logic                    txWordValid,
  output logic                    txWordReady,
  input  logic                    txSent,
  output logic [7:0]              txByte,
  output logic                    txReady
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HIGH,
    TX_LOW
  } txState_t;

  txState_t   state;
  logic [7:0] lowByte; // second half, sent after the first txSent

  assign txWordReady = (state == TX_IDLE);

  always_ff @(posedge iClock) begin
    txReady <= 1'b0;
    if (reset) begin
      state <= TX_IDLE;
    end else begin
      case (state)
        TX_IDLE: begin
          if (txWordValid) begin
            txByte  <= txWord.bytes[1]; // high byte first
            lowByte <= txWord.bytes[0];
            txReady <= 1'b1;
            state   <= TX_HIGH;
          end
        end
        TX_HIGH: begin
          if (txSent) begin
            txByte  <= lowByte;
            txReady <= 1'b1;
            state   <= TX_LOW;
          end
        end
        TX_LOW: begin
          if (txSent) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // the UART only reports bytes that were handed to it
  assert property (@(posedge iClock) disable iff (reset)
    state == TX_IDLE |-> !txSent);

endmodule

`default_nettype wire

/* uartWordRx.sv */
`timescale 1ns/10ps
`include "gpuMemCtrl_macros.svh"
`default_nettype none

module uartWordRx (
  input  logic                    iClock,
  input  logic                    reset,
  input  logic [7:0]              rxByte,
  input  logic                    rxReady,
  input  logic                    rxError,
  output hostProtoPkg::hostWord_t word,
  output logic                    wordValid
);

  logic haveHigh; // first byte of the pair is held

  always_ff @(posedge iClock) begin
    wordValid <= 1'b0;
    if (reset) begin
      haveHigh <= 1'b0;
    end else if (rxError) begin
      haveHigh <= 1'b0; // drop a half word
    end else if (rxReady) begin
      if (!haveHigh) begin
        word.bytes[1] <= rxByte;
      end else begin
        word.bytes[0] <= rxByte;
        wordValid     <= 1'b1;
      end
      haveHigh <= !haveHigh;
    end
  end

endmodule

`default_nettype wire

/* sramScenePkg.sv */
`include "gpuMemCtrl_macros.svh"
`default_nettype none

package sramScenePkg;

  typedef logic [`ADDR_WIDTH-1:0] sramAddr_t;
  typedef logic [`WORD_WIDTH-1:0] sramData_t;

  // camera word order inside the scene block
  typedef enum logic [1:0] {
    CAM_VER_X,
    CAM_VER_Y,
    CAM_VER_Z,
    CAM_DC
  } camIndex_t;

endpackage

`default_nettype wire

/* hostProtoPkg.sv */
`include "gpuMemCtrl_macros.svh"
`default_nettype none

package hostProtoPkg;

  // protocol tags, shared with the host driver
  typedef enum logic [`WORD_WIDTH-1:0] {
    TAG_REQUEST = 16'hAAAA,
    TAG_GPU     = 16'hCCCC,
    TAG_CAM     = 16'hBBBB,
    TAG_OBJ     = 16'hEEEE,
    TAG_CLS_OBJ = 16'h8888,
    TAG_TMATRIX = 16'hABCD,
    TAG_REFRESH = 16'h1234,
    TAG_FINAL   = 16'hFFFF,
    TAG_ERROR   = 16'h1414,
    TAG_BUSY    = 16'h4141
  } cmdTag_t;

  // one link word, seen as a tag or as two UART bytes
  typedef union packed {
    cmdTag_t                               tag;
    logic [1:0][`WORD_WIDTH/2-1:0]         bytes; // [1] goes out first
  } hostWord_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_REFRESH
  } cmdState_t;

endpackage

`default_nettype wire

/* gpuMemCtrl_macros.svh */
`ifndef GPU_MEM_CTRL_MACROS_SVH
`define GPU_MEM_CTRL_MACROS_SVH

`default_nettype none

// bus widths
`define WORD_WIDTH 16
`define ADDR_WIDTH 22

// data words per write command, final tag not counted
`define INIT_BLOCK_SIZE    2
`define CAM_BLOCK_SIZE     5
`define OBJ_BLOCK_SIZE     14
`define CLS_OBJ_BLOCK_SIZE 1
`define MATRIX_BLOCK_SIZE  12

// scene layout seen by refresh
`define SCENE_BASE_ADDR 0
`define CAM_WORDS       4

`default_nettype wire

`endif
